//--- test/ppu_stim.txt
# W addr data | R addr expected (hex); P y x shade | D frames | S stat rises per frame
# Setup with the display off
W FF40 00
W FF47 E4
R FF47 E4
W FF42 5A
R FF42 5A
W FF43 C3
R FF43 C3
W FF42 00
W FF43 00
W FF45 05
R FF45 05
W FF41 F8
R FF41 F8
W FF41 40
R FF41 40
# Tile 1 rows 0 and 1, map row 0 columns 0 and 1
W 8010 55
W 8011 33
W 8012 FF
W 8013 00
W 9800 01
W 9801 01
R 8010 55
R 9801 01
W FF40 91
S 1
P 0 0 0
P 0 1 1
P 0 2 2
P 0 3 3
P 0 5 1
P 0 10 2
P 1 0 1
P 1 7 1
P 1 8 1
D 2
# Scrolled frame with signed tile data and inverted palette
W FF43 03
W FF42 01
W FF47 1B
W 9012 0F
W 9013 F0
W 8FF2 FF
W 8FF3 FF
W 9801 FF
W FF40 81
P 0 0 1
P 0 1 2
P 0 4 2
P 0 5 0
P 0 12 0
D 2
# Display off
S 0
W FF40 01
R FF44 00
R FF41 40
D 1

//--- filelist.f
rtl/ppu_pkg.sv
rtl/ppu_regs.sv
rtl/lcd_timing.sv
rtl/video_ram.sv
rtl/bg_fetcher.sv
rtl/pixel_streamer.sv
rtl/ppu_top.sv
test/ppu_checker.sv
test/ppu_tb.sv

//--- Bender.yml
package:
  name: ppu

sources:
  - rtl/ppu_pkg.sv
  - rtl/ppu_regs.sv
  - rtl/lcd_timing.sv
  - rtl/video_ram.sv
  - rtl/bg_fetcher.sv
  - rtl/pixel_streamer.sv
  - rtl/ppu_top.sv
  - target: test
    files:
      - test/ppu_checker.sv
      - test/ppu_tb.sv

//--- test/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

   localparam int  CLOCK_PERIOD = 40;
   localparam int  FRAME_CLOCKS = DOT_DIVIDE * DOTS_PER_LINE * LINES_PER_FRAME;

   logic      clock;
   logic      reset;
   bus_addr_t bus_addr;
   byte_t     bus_wdata;
   logic      bus_read;
   logic      bus_write;
   byte_t     bus_rdata;
   logic      vblank_req;
   logic      vblank_ack;
   logic      stat_req;
   logic      stat_ack;
   logic      pixel_valid;
   logic      pixel_ready;
   color_t    pixel_shade;
   pixel_x_t  pixel_x;
   line_t     pixel_y;
   // Display state as last written through LCDC
   logic      display_expected;

   logic [31:0] lfsr_state;

   // Parsed stimulus
   byte cmd_q [$];
   int  arg_a [$];
   int  arg_b [$];
   int  arg_c [$];
   int  total_frames;
   int  stim_errors;

   ppu_top dut (.*);

   ppu_checker monitor (.*);

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   task automatic write_bus(input int addr, input int data);
      @(posedge clock);
      #1;
      bus_addr  = addr[15:0];
      bus_wdata = data[7:0];
      bus_write = 1'b1;
      @(posedge clock);
      #1;
      bus_write = 1'b0;
      if (addr[15:0] == REG_LCDC)
         display_expected = data[7];
   endtask

   // Data settles on the edge after the strobe
   task automatic read_bus(input int addr, input int value);
      @(posedge clock);
      #1;
      bus_addr = addr[15:0];
      bus_read = 1'b1;
      @(posedge clock);
      #1;
      bus_read = 1'b0;
      monitor.compare_read(addr, value);
   endtask

   // Counts V-blank entries while the display runs
   // Fixed frame time while it is off
   task automatic wait_frames(input int count);
      if (display_expected) begin
         repeat (count) @(posedge vblank_req);
      end else begin
         repeat (count * FRAME_CLOCKS) @(posedge clock);
      end
   endtask

   task automatic load_stimulus();
      int  fd;
      int  a;
      int  b;
      int  c;
      byte op;
      string text;
      total_frames = 0;
      fd = $fopen("test/ppu_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file test/ppu_stim.txt");
         stim_errors++;
      end else begin
         while ($fgets(text, fd)) begin
            if (text.len() > 1 && text[0] != "#") begin
               a = 0;
               b = 0;
               c = 0;
               op = text[0];
               if (op == "W" || op == "R")
                  void'($sscanf(text, "%c %h %h", op, a, b));
               else
                  void'($sscanf(text, "%c %d %d %d", op, a, b, c));
               if (op == "D")
                  total_frames += a;
               cmd_q.push_back(op);
               arg_a.push_back(a);
               arg_b.push_back(b);
               arg_c.push_back(c);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic report_and_finish();
      int errors;
      errors = monitor.pixel_errors + monitor.read_errors + monitor.irq_errors
             + stim_errors;
      $display("Errors: %0d total, %0d pixel, %0d read, %0d interrupt, %0d stimulus",
               errors, monitor.pixel_errors, monitor.read_errors, monitor.irq_errors,
               stim_errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   ////////////////////////////////////////
   // Ready and interrupt acks
   ////////////////////////////////////////

   // Ready high on three of four draws
   // Acks follow the requests
   always @(posedge clock) begin
      #1;
      pixel_ready = !(lfsr_bit() & lfsr_bit());
      vblank_ack  = vblank_req;
      stat_ack    = stat_req;
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      longint limit;
      logic   new_group;
      reset            = 1'b1;
      bus_addr         = '0;
      bus_wdata        = '0;
      bus_read         = 1'b0;
      bus_write        = 1'b0;
      vblank_ack       = 1'b0;
      stat_ack         = 1'b0;
      pixel_ready      = 1'b0;
      display_expected = 1'b1;
      lfsr_state       = 32'hd011a15b;
      new_group        = 1'b1;
      stim_errors      = 0;

      load_stimulus();

      limit = longint'(total_frames + 2) * FRAME_CLOCKS * CLOCK_PERIOD;
      fork
         begin
            #(limit);
            $display("Timeout after %0d ns, the stimulus did not complete", $time);
            $display("Finished with errors");
            $finish;
         end
      join_none

      repeat (10) @(posedge clock);
      #1;
      reset = 1'b0;

      foreach (cmd_q[i]) begin
         // A fresh run of P lines replaces the old expectations
         if (cmd_q[i] == "P" && new_group)
            monitor.forget_pixels();
         new_group = (cmd_q[i] != "P");
         case (cmd_q[i])
            "W": write_bus(arg_a[i], arg_b[i]);
            "R": read_bus(arg_a[i], arg_b[i]);
            "P": monitor.expect_pixel(arg_a[i], arg_b[i], arg_c[i]);
            "D": wait_frames(arg_a[i]);
            "S": monitor.expect_stat_per_frame(arg_a[i]);
            default: begin
               $display("Unknown stimulus command %c in the stimulus file", cmd_q[i]);
               stim_errors++;
            end
         endcase
      end

      repeat (4) @(posedge clock);
      report_and_finish();
   end

endmodule

//--- test/ppu_checker.sv
`timescale 1ns/1ps

module ppu_checker import ppu_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  byte_t     bus_rdata,
   input  logic      vblank_req,
   input  logic      vblank_ack,
   input  logic      stat_req,
   input  logic      stat_ack,
   input  logic      pixel_valid,
   input  logic      pixel_ready,
   input  color_t    pixel_shade,
   input  pixel_x_t  pixel_x,
   input  line_t     pixel_y,
   input  logic      display_expected
);

   // Bit 2 marks an entry that holds an expected shade
   logic [2:0] expected [VISIBLE_LINES * VISIBLE_WIDTH];

   int pixel_errors;
   int read_errors;
   int irq_errors;
   int stat_per_frame;

   // Stream position the next accepted pixel must have
   int next_x;
   int next_y;
   int stat_rises;

   logic     vblank_q;
   logic     stat_q;
   logic     vblank_ack_q;
   logic     stat_ack_q;
   logic     held;
   color_t   held_shade;
   pixel_x_t held_x;
   line_t    held_y;

   initial begin
      pixel_errors   = 0;
      read_errors    = 0;
      irq_errors     = 0;
      stat_per_frame = 0;
      next_x         = 0;
      next_y         = 0;
      stat_rises     = 0;
      forget_pixels();
   end

   ////////////////////////////////////////
   // Tasks called by the testbench
   ////////////////////////////////////////

   task automatic forget_pixels();
      for (int i = 0; i < VISIBLE_LINES * VISIBLE_WIDTH; i++)
         expected[i] = 3'b000;
   endtask

   task automatic expect_pixel(input int y, input int x, input int shade);
      expected[y * VISIBLE_WIDTH + x] = {1'b1, shade[1:0]};
   endtask

   // Zero switches the per-frame count check off
   task automatic expect_stat_per_frame(input int count);
      stat_per_frame = count;
   endtask

   // Called once the read data has settled
   task automatic compare_read(input int addr, input int value);
      if (bus_rdata !== value[7:0]) begin
         $display("ERROR %0t ns: bus_rdata at %h expected %h got %h",
                  $time, addr[15:0], value[7:0], bus_rdata);
         read_errors++;
      end
   endtask

   ////////////////////////////////////////
   // Pixel stream
   ////////////////////////////////////////

   always @(posedge clock) begin
      if (!reset) begin
         // Payload frozen under back-pressure
         if (held) begin
            if (!pixel_valid) begin
               $display("Pixel output was withdrawn before it was accepted at %0t ns",
                        $time);
               pixel_errors++;
            end
            if (pixel_shade !== held_shade) begin
               $display("ERROR %0t ns: pixel_shade while stalled expected %0d got %0d",
                        $time, held_shade, pixel_shade);
               pixel_errors++;
            end
            if (pixel_x !== held_x) begin
               $display("ERROR %0t ns: pixel_x while stalled expected %0d got %0d",
                        $time, held_x, pixel_x);
               pixel_errors++;
            end
            if (pixel_y !== held_y) begin
               $display("ERROR %0t ns: pixel_y while stalled expected %0d got %0d",
                        $time, held_y, pixel_y);
               pixel_errors++;
            end
         end
         held       <= pixel_valid && !pixel_ready;
         held_shade <= pixel_shade;
         held_x     <= pixel_x;
         held_y     <= pixel_y;

         if (pixel_valid && !display_expected) begin
            $display("Pixel output was valid while the display was switched off at %0t ns",
                     $time);
            pixel_errors++;
         end

         if (pixel_valid && pixel_ready) begin
            if (pixel_x !== next_x[7:0] || pixel_y !== next_y[7:0]) begin
               $display("ERROR %0t ns: pixel_y,pixel_x expected %0d,%0d got %0d,%0d",
                        $time, next_y, next_x, pixel_y, pixel_x);
               pixel_errors++;
            end else if (expected[pixel_y * VISIBLE_WIDTH + pixel_x][2]
                         && pixel_shade !== expected[pixel_y * VISIBLE_WIDTH + pixel_x][1:0])
            begin
               $display("ERROR %0t ns: pixel_shade at %0d,%0d expected %0d got %0d",
                        $time, pixel_y, pixel_x,
                        expected[pixel_y * VISIBLE_WIDTH + pixel_x][1:0], pixel_shade);
               pixel_errors++;
            end
            // Resync on the DUT position after a mismatch
            if (pixel_x == VISIBLE_WIDTH - 1) begin
               next_x = 0;
               next_y = pixel_y + 1;
            end else begin
               next_x = pixel_x + 1;
               next_y = pixel_y;
            end
         end
      end else begin
         held <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // Interrupts
   ////////////////////////////////////////

   always @(posedge clock) begin
      if (reset) begin
         vblank_q     <= 1'b0;
         stat_q       <= 1'b0;
         vblank_ack_q <= 1'b0;
         stat_ack_q   <= 1'b0;
      end else begin
         vblank_q     <= vblank_req;
         stat_q       <= stat_req;
         vblank_ack_q <= vblank_ack;
         stat_ack_q   <= stat_ack;

         // An ack must have cleared the request by now
         if (vblank_ack_q && vblank_req) begin
            $display("ERROR %0t ns: vblank_req after ack expected 0 got 1", $time);
            irq_errors++;
         end
         if (stat_ack_q && stat_req) begin
            $display("ERROR %0t ns: stat_req after ack expected 0 got 1", $time);
            irq_errors++;
         end

         if (stat_req && !stat_q)
            stat_rises++;

         if (vblank_req && !vblank_q) begin
            // Whole frame streamed before V-blank
            if (next_x != 0 || next_y != VISIBLE_LINES || pixel_valid) begin
               $display("ERROR %0t ns: pixel_y at vblank_req expected %0d got %0d (x %0d)",
                        $time, VISIBLE_LINES, next_y, next_x);
               irq_errors++;
            end
            if (stat_per_frame != 0 && stat_rises != stat_per_frame) begin
               $display("ERROR %0t ns: stat_req rises per frame expected %0d got %0d",
                        $time, stat_per_frame, stat_rises);
               irq_errors++;
            end
            stat_rises = 0;
            next_x     = 0;
            next_y     = 0;
         end
      end
   end

endmodule

//--- rtl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   // CPU strobe bus
   input  bus_addr_t bus_addr,
   input  byte_t     bus_wdata,
   input  logic      bus_read,
   input  logic      bus_write,
   output byte_t     bus_rdata,
   // Interrupt requests
   output logic      vblank_req,
   input  logic      vblank_ack,
   output logic      stat_req,
   input  logic      stat_ack,
   // Pixel stream
   output logic      pixel_valid,
   input  logic      pixel_ready,
   output color_t    pixel_shade,
   output pixel_x_t  pixel_x,
   output line_t     pixel_y
);

   lcd_mode_t  mode;
   line_t      line;
   logic       coincidence;
   logic       line_start_transfer;
   byte_t      lcdc;
   byte_t      scy;
   byte_t      scx;
   byte_t      lyc;
   byte_t      bgp;
   logic [3:0] stat_enables;
   vram_addr_t vram_cpu_addr;
   byte_t      vram_cpu_wdata;
   logic       vram_cpu_we;
   byte_t      vram_cpu_rdata;
   vram_addr_t fetch_addr;
   byte_t      fetch_rdata;
   logic       buf_we;
   pixel_x_t   buf_addr;
   color_t     buf_color;
   logic       fetch_done;

   ppu_regs regs (
      .clock          (clock),
      .reset          (reset),
      .bus_addr       (bus_addr),
      .bus_wdata      (bus_wdata),
      .bus_read       (bus_read),
      .bus_write      (bus_write),
      .bus_rdata      (bus_rdata),
      .mode           (mode),
      .line           (line),
      .coincidence    (coincidence),
      .vram_rdata     (vram_cpu_rdata),
      .lcdc           (lcdc),
      .scy            (scy),
      .scx            (scx),
      .lyc            (lyc),
      .bgp            (bgp),
      .stat_enables   (stat_enables),
      .vram_cpu_addr  (vram_cpu_addr),
      .vram_cpu_wdata (vram_cpu_wdata),
      .vram_cpu_we    (vram_cpu_we)
   );

   // LCDC bit 7 switches the display
   lcd_timing timing (
      .clock               (clock),
      .reset               (reset),
      .display_on          (lcdc[7]),
      .lyc                 (lyc),
      .stat_enables        (stat_enables),
      .vblank_ack          (vblank_ack),
      .stat_ack            (stat_ack),
      .mode                (mode),
      .line                (line),
      .coincidence         (coincidence),
      .line_start_transfer (line_start_transfer),
      .vblank_req          (vblank_req),
      .stat_req            (stat_req)
   );

   video_ram vram (
      .clock       (clock),
      .cpu_addr    (vram_cpu_addr),
      .cpu_wdata   (vram_cpu_wdata),
      .cpu_we      (vram_cpu_we),
      .cpu_rdata   (vram_cpu_rdata),
      .fetch_addr  (fetch_addr),
      .fetch_rdata (fetch_rdata)
   );

   bg_fetcher fetcher (
      .clock       (clock),
      .reset       (reset),
      .start       (line_start_transfer),
      .line        (line),
      .scx         (scx),
      .scy         (scy),
      .lcdc        (lcdc),
      .fetch_rdata (fetch_rdata),
      .fetch_addr  (fetch_addr),
      .buf_we      (buf_we),
      .buf_addr    (buf_addr),
      .buf_color   (buf_color),
      .fetch_done  (fetch_done)
   );

   // Next transfer cuts off an unfinished line
   pixel_streamer streamer (
      .clock       (clock),
      .reset       (reset),
      .start       (fetch_done),
      .abort       (line_start_transfer),
      .line        (line),
      .bgp         (bgp),
      .buf_we      (buf_we),
      .buf_addr    (buf_addr),
      .buf_color   (buf_color),
      .pixel_ready (pixel_ready),
      .pixel_valid (pixel_valid),
      .pixel_shade (pixel_shade),
      .pixel_x     (pixel_x),
      .pixel_y     (pixel_y)
   );

endmodule

//--- rtl/pixel_streamer.sv
`timescale 1ns/1ps

module pixel_streamer import ppu_pkg::*; (
   input  logic     clock,
   input  logic     reset,
   input  logic     start,
   input  logic     abort,
   input  line_t    line,
   input  byte_t    bgp,
   input  logic     buf_we,
   input  pixel_x_t buf_addr,
   input  color_t   buf_color,
   input  logic     pixel_ready,
   output logic     pixel_valid,
   output color_t   pixel_shade,
   output pixel_x_t pixel_x,
   output line_t    pixel_y
);

   // Colour indices for one line
   color_t   line_buf [VISIBLE_WIDTH];
   logic     active;
   pixel_x_t rd_ptr;
   // Read stage ahead of the output register
   logic     rd_valid;
   color_t   rd_color;
   pixel_x_t rd_x;
   line_t    cur_line;
   logic     out_load;
   logic     issue;

   always_ff @(posedge clock) begin
      if (buf_we) begin
         line_buf[buf_addr] <= buf_color;
      end
   end

   // Output free or being taken this cycle
   assign out_load = !pixel_valid || pixel_ready;
   assign issue    = active && (!rd_valid || out_load);

   ////////////////////////////////////////
   // Read pointer and handshake
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset || abort) begin
         active      <= 1'b0;
         rd_ptr      <= '0;
         rd_valid    <= 1'b0;
         pixel_valid <= 1'b0;
      end else begin
         if (start) begin
            active <= 1'b1;
            rd_ptr <= '0;
         end else if (issue) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (rd_ptr == VISIBLE_WIDTH - 1)
               active <= 1'b0;
         end
         if (issue)
            rd_valid <= 1'b1;
         else if (out_load)
            rd_valid <= 1'b0;
         if (out_load)
            pixel_valid <= rd_valid;
      end
   end

   // Payload, palette applied on the way out
   always_ff @(posedge clock) begin
      if (start) begin
         cur_line <= line;
      end
      if (issue) begin
         rd_color <= line_buf[rd_ptr];
         rd_x     <= rd_ptr;
      end
      if (out_load && rd_valid) begin
         pixel_shade <= bgp[{rd_color, 1'b0} +: 2];
         pixel_x     <= rd_x;
         pixel_y     <= cur_line;
      end
   end

endmodule

//--- rtl/bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher import ppu_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  logic       start,
   input  line_t      line,
   input  byte_t      scx,
   input  byte_t      scy,
   input  byte_t      lcdc,
   input  byte_t      fetch_rdata,
   output vram_addr_t fetch_addr,
   output logic       buf_we,
   output pixel_x_t   buf_addr,
   output color_t     buf_color,
   output logic       fetch_done
);

   fetch_state_t state;
   logic [4:0]   col;
   logic [2:0]   bit_idx;
   byte_t        tile_num;
   byte_t        low_byte;
   byte_t        bg_y;
   logic [4:0]   map_col;
   vram_addr_t   map_addr;
   byte_t        tile_sel;
   vram_addr_t   row_addr;
   logic [8:0]   screen_x;
   logic         last_pixel;

   ////////////////////////////////////////
   // Address generation
   ////////////////////////////////////////

   // Background row, wraps at 256
   assign bg_y    = scy + line;
   // Map column wraps at 32
   assign map_col = scx[7:3] + col;
   assign map_addr = (lcdc[3] ? MAP_BASE_HIGH : MAP_BASE_LOW)
                   + vram_addr_t'({bg_y[7:3], map_col});

   // Tile number straight off the RAM in the index state
   assign tile_sel = (state == FETCH_INDEX) ? fetch_rdata : tile_num;

   // Unsigned from 0, signed around the centre
   always_comb begin
      if (lcdc[4])
         row_addr = {1'b0, tile_sel, bg_y[2:0], 1'b0};
      else
         row_addr = DATA_BASE_SIGNED + {tile_sel[7], tile_sel, 4'b0000}
                  + {bg_y[2:0], 1'b0};
   end

   // High byte address held through the pixel writes
   always_comb begin
      case (state)
         FETCH_MAP:   fetch_addr = map_addr;
         FETCH_INDEX: fetch_addr = row_addr;
         default:     fetch_addr = row_addr + 13'd1;
      endcase
   end

   ////////////////////////////////////////
   // Pixel writes
   ////////////////////////////////////////

   // Fine scroll shifts the whole line left
   assign screen_x  = {1'b0, col, bit_idx} - {6'b0, scx[2:0]};
   assign buf_addr  = screen_x[7:0];
   assign buf_we    = (state == FETCH_PIXELS) && (screen_x < VISIBLE_WIDTH);
   // Leftmost pixel in bit 7, colour 0 with background off
   assign buf_color = lcdc[0] ? {fetch_rdata[3'd7 - bit_idx], low_byte[3'd7 - bit_idx]}
                              : 2'b00;

   assign last_pixel = (state == FETCH_PIXELS) && (bit_idx == 3'd7)
                    && (col == TILES_PER_LINE - 1);

   always_ff @(posedge clock) begin
      if (reset) begin
         state      <= FETCH_IDLE;
         col        <= '0;
         bit_idx    <= '0;
         fetch_done <= 1'b0;
      end else begin
         fetch_done <= last_pixel;
         case (state)
            FETCH_IDLE: begin
               if (start) begin
                  col   <= '0;
                  state <= FETCH_MAP;
               end
            end
            FETCH_MAP:   state <= FETCH_INDEX;
            FETCH_INDEX: state <= FETCH_LOW;
            FETCH_LOW: begin
               bit_idx <= '0;
               state   <= FETCH_PIXELS;
            end
            FETCH_PIXELS: begin
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 3'd7) begin
                  col <= col + 1'b1;
                  if (col == TILES_PER_LINE - 1)
                     state <= FETCH_IDLE;
                  else
                     state <= FETCH_MAP;
               end
            end
            default: state <= FETCH_IDLE;
         endcase
      end
   end

   // Tile number and low plane
   always_ff @(posedge clock) begin
      if (state == FETCH_INDEX) begin
         tile_num <= fetch_rdata;
      end
      if (state == FETCH_LOW) begin
         low_byte <= fetch_rdata;
      end
   end

endmodule

//--- rtl/video_ram.sv
`timescale 1ns/1ps

module video_ram import ppu_pkg::*; (
   input  logic       clock,
   input  vram_addr_t cpu_addr,
   input  byte_t      cpu_wdata,
   input  logic       cpu_we,
   output byte_t      cpu_rdata,
   input  vram_addr_t fetch_addr,
   output byte_t      fetch_rdata
);

   // 8 KB, both ports registered
   byte_t mem [VRAM_LIMIT - VRAM_BASE];

   // CPU port, read gives the old byte on a write
   always_ff @(posedge clock) begin
      if (cpu_we) begin
         mem[cpu_addr] <= cpu_wdata;
      end
      cpu_rdata <= mem[cpu_addr];
   end

   // Fetch port, read only
   always_ff @(posedge clock) begin
      fetch_rdata <= mem[fetch_addr];
   end

endmodule

//--- rtl/lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing import ppu_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  logic       display_on,
   input  line_t      lyc,
   input  logic [3:0] stat_enables,
   input  logic       vblank_ack,
   input  logic       stat_ack,
   output lcd_mode_t  mode,
   output line_t      line,
   output logic       coincidence,
   output logic       line_start_transfer,
   output logic       vblank_req,
   output logic       stat_req
);

   logic [$clog2(DOT_DIVIDE)-1:0] div;
   dot_t      dot;
   logic      dot_tick;
   lcd_mode_t next_mode;
   logic      entering;
   logic      lyc_hit;
   logic      stat_event;

   assign dot_tick = (div == DOT_DIVIDE - 1);

   ////////////////////////////////////////
   // Dot and line counters
   ////////////////////////////////////////

   // Held at zero while the display is off
   always_ff @(posedge clock) begin
      if (reset || !display_on) begin
         div  <= '0;
         dot  <= '0;
         line <= '0;
      end else begin
         div <= dot_tick ? '0 : div + 1'b1;
         if (dot_tick) begin
            if (dot == DOTS_PER_LINE - 1) begin
               dot  <= '0;
               line <= (line == LINES_PER_FRAME - 1) ? '0 : line + 1'b1;
            end else begin
               dot <= dot + 1'b1;
            end
         end
      end
   end

   // Mode from the counters, registered below
   always_comb begin
      if (!display_on)
         next_mode = MODE_HBLANK;
      else if (line >= VISIBLE_LINES)
         next_mode = MODE_VBLANK;
      else if (dot < OAM_DOTS)
         next_mode = MODE_OAM;
      else if (dot < OAM_DOTS + TRANSFER_DOTS)
         next_mode = MODE_TRANSFER;
      else
         next_mode = MODE_HBLANK;
   end

   // Display switching off raises nothing
   assign entering = display_on && (next_mode != mode);
   // Once per line, first clock of dot 0
   assign lyc_hit  = display_on && (dot == '0) && (div == '0) && (line == lyc);

   assign stat_event = (entering && next_mode == MODE_HBLANK && stat_enables[0])
                    || (entering && next_mode == MODE_VBLANK && stat_enables[1])
                    || (entering && next_mode == MODE_OAM && stat_enables[2])
                    || (lyc_hit && stat_enables[3]);

   assign coincidence = (line == lyc);

   ////////////////////////////////////////
   // Mode and interrupts
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         mode                <= MODE_HBLANK;
         line_start_transfer <= 1'b0;
         vblank_req          <= 1'b0;
         stat_req            <= 1'b0;
      end else begin
         mode                <= next_mode;
         line_start_transfer <= entering && (next_mode == MODE_TRANSFER);
         // New request beats an ack in the same cycle
         if (entering && next_mode == MODE_VBLANK)
            vblank_req <= 1'b1;
         else if (vblank_ack)
            vblank_req <= 1'b0;
         if (stat_event)
            stat_req <= 1'b1;
         else if (stat_ack)
            stat_req <= 1'b0;
      end
   end

endmodule

//--- rtl/ppu_regs.sv
`timescale 1ns/1ps

module ppu_regs import ppu_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  bus_addr_t  bus_addr,
   input  byte_t      bus_wdata,
   input  logic       bus_read,
   input  logic       bus_write,
   output byte_t      bus_rdata,
   input  lcd_mode_t  mode,
   input  line_t      line,
   input  logic       coincidence,
   input  byte_t      vram_rdata,
   output byte_t      lcdc,
   output byte_t      scy,
   output byte_t      scx,
   output byte_t      lyc,
   output byte_t      bgp,
   output logic [3:0] stat_enables,
   output vram_addr_t vram_cpu_addr,
   output byte_t      vram_cpu_wdata,
   output logic       vram_cpu_we
);

   // STAT bits 7..3, bits 2..0 are live status
   logic [4:0] stat_bits;
   logic       in_vram;
   logic       vram_open;
   logic       read_vram;
   byte_t      read_q;

   assign in_vram = (bus_addr >= VRAM_BASE) && (bus_addr < VRAM_LIMIT);
   // Fetcher owns VRAM during transfer
   assign vram_open = (mode != MODE_TRANSFER);

   assign vram_cpu_addr  = vram_addr_t'(bus_addr - VRAM_BASE);
   assign vram_cpu_wdata = bus_wdata;
   assign vram_cpu_we    = bus_write && in_vram && vram_open;

   // Interrupt selects, STAT bits 6..3
   assign stat_enables = stat_bits[3:0];

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         // Display on, background on, unsigned tile data
         lcdc      <= 8'h91;
         stat_bits <= '0;
         scy       <= '0;
         scx       <= '0;
         lyc       <= '0;
         bgp       <= '0;
      end else if (bus_write) begin
         case (bus_addr)
            REG_LCDC: lcdc <= bus_wdata;
            REG_STAT: stat_bits <= bus_wdata[7:3];
            REG_SCY:  scy <= bus_wdata;
            REG_SCX:  scx <= bus_wdata;
            REG_LYC:  lyc <= bus_wdata;
            REG_BGP:  bgp <= bus_wdata;
            // LY is read only
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Readback
   ////////////////////////////////////////

   // VRAM data arrives one clock after the strobe
   always_ff @(posedge clock) begin
      if (reset) begin
         read_vram <= 1'b0;
      end else if (bus_read) begin
         read_vram <= in_vram && vram_open;
      end
   end

   // Locked VRAM and unmapped space fall to FF
   always_ff @(posedge clock) begin
      if (bus_read) begin
         case (bus_addr)
            REG_LCDC: read_q <= lcdc;
            REG_STAT: read_q <= {stat_bits, coincidence, mode};
            REG_SCY:  read_q <= scy;
            REG_SCX:  read_q <= scx;
            REG_LY:   read_q <= line;
            REG_LYC:  read_q <= lyc;
            REG_BGP:  read_q <= bgp;
            default:  read_q <= 8'hFF;
         endcase
      end
   end

   assign bus_rdata = read_vram ? vram_rdata : read_q;

endmodule

//--- rtl/ppu_pkg.sv
package ppu_pkg;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////

   typedef logic [15:0] bus_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [12:0] vram_addr_t;
   typedef logic [8:0]  dot_t;
   typedef logic [7:0]  line_t;
   typedef logic [7:0]  pixel_x_t;
   typedef logic [1:0]  color_t;

   // Encoded exactly as the STAT mode field
   typedef enum logic [1:0] {
      MODE_HBLANK   = 2'd0,
      MODE_VBLANK   = 2'd1,
      MODE_OAM      = 2'd2,
      MODE_TRANSFER = 2'd3
   } lcd_mode_t;

   // Background fetcher states
   typedef enum logic [2:0] {
      FETCH_IDLE,
      FETCH_MAP,
      FETCH_INDEX,
      FETCH_LOW,
      FETCH_PIXELS
   } fetch_state_t;

   ////////////////////////////////////////
   // Timing
   ////////////////////////////////////////

   localparam int DOT_DIVIDE      = 8;
   localparam int DOTS_PER_LINE   = 456;
   localparam int LINES_PER_FRAME = 154;
   localparam int VISIBLE_LINES   = 144;
   localparam int VISIBLE_WIDTH   = 160;
   localparam int OAM_DOTS        = 80;
   localparam int TRANSFER_DOTS   = 172;
   // One extra column covers a partial tile under fine scroll
   localparam int TILES_PER_LINE  = 21;

   ////////////////////////////////////////
   // Address map
   ////////////////////////////////////////

   localparam bus_addr_t VRAM_BASE  = 16'h8000;
   localparam bus_addr_t VRAM_LIMIT = 16'hA000;

   localparam bus_addr_t REG_LCDC = 16'hFF40;
   localparam bus_addr_t REG_STAT = 16'hFF41;
   localparam bus_addr_t REG_SCY  = 16'hFF42;
   localparam bus_addr_t REG_SCX  = 16'hFF43;
   localparam bus_addr_t REG_LY   = 16'hFF44;
   localparam bus_addr_t REG_LYC  = 16'hFF45;
   localparam bus_addr_t REG_BGP  = 16'hFF47;

   // Offsets inside VRAM
   localparam vram_addr_t MAP_BASE_LOW     = 13'h1800;
   localparam vram_addr_t MAP_BASE_HIGH    = 13'h1C00;
   localparam vram_addr_t DATA_BASE_SIGNED = 13'h1000;

endpackage
